/* rv_decode.f */
+incdir+source
+incdir+bench
source/rv_decode_pkg.sv
source/main_decoder.sv
source/imm_gen.sv
source/regfile.sv
source/instruction_decode_stage.sv
bench/id_stage_tb.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - include_dirs:
      - source
    files:
      - source/rv_decode_pkg.sv
      - source/main_decoder.sv
      - source/imm_gen.sv
      - source/regfile.sv
      - source/instruction_decode_stage.sv
  - target: test
    include_dirs:
      - source
      - bench
    files:
      - bench/id_stage_tb.sv

/* bench/id_stage_model.svh */
`ifndef ID_STAGE_MODEL_SVH
`define ID_STAGE_MODEL_SVH

////////////////////////////////////////////////////////////
// Shadow register file
////////////////////////////////////////////////////////////

logic [`RV_XLEN-1:0] shadow_rf [`RV_NREGS];   // x0 kept at zero

function automatic void clear_shadow();
   for (int i = 0; i < `RV_NREGS; i++)
      shadow_rf[i] = '0;
endfunction

// A write in the same cycle is seen through the bypass
function automatic logic [`RV_XLEN-1:0] shadow_read(input logic [4:0] addr,
                                                    input rv_decode_pkg::rf_wr_t wr);
   if (addr == 5'd0)
      return '0;
   if (wr.en && (wr.addr == addr))
      return wr.data;
   return shadow_rf[addr];
endfunction

////////////////////////////////////////////////////////////
// Decode reference
////////////////////////////////////////////////////////////

function automatic logic [31:0] expected_imm(input logic [31:0] ins);
   case (ins[6:0])
      7'b0100011: return {{20{ins[31]}}, ins[31:25], ins[11:7]};   // S
      7'b1100011: return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      7'b0110111, 7'b0010111: return {ins[31:12], 12'h000};   // LUI, AUIPC
      7'b1101111: return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      default: return {{20{ins[31]}}, ins[31:20]};   // I, also OP and SYSTEM
   endcase
endfunction

// Load in EX whose rd matches either source field
function automatic logic expected_stall(input rv_decode_pkg::id_ex_t ex, input logic [31:0] ins);
   return ex.is_load && (ex.rd != 5'd0) && ((ex.rd == ins[19:15]) || (ex.rd == ins[24:20]));
endfunction

function automatic rv_decode_pkg::id_ex_t expected_decode(input logic [31:0] ins,
                                                         input logic [29:0] pc,
                                                         input rv_decode_pkg::rf_wr_t wr);
   rv_decode_pkg::id_ex_t e;
   logic [6:0]            opc;
   logic                  is_jal;
   logic                  is_alu;   // OP or OP_IMM
   opc       = ins[6:0];
   is_jal    = (opc == 7'b1101111);
   is_alu    = (opc == 7'b0110011) || (opc == 7'b0010011);
   e         = '0;
   e.pc      = pc;
   e.rd      = ins[11:7];
   e.funct3  = ins[14:12];
   e.rs1     = ins[19:15];
   e.rs2     = ins[24:20];
   e.funct7  = ins[31:25];
   e.rs1_val = shadow_read(e.rs1, wr);
   e.rs2_val = shadow_read(e.rs2, wr);
   e.imm     = expected_imm(ins);
   e.is_load   = (opc == 7'b0000011);
   e.is_store  = (opc == 7'b0100011);
   e.is_branch = (opc == 7'b1100011);
   e.is_jump   = is_jal || (opc == 7'b1100111);
   e.is_system = (opc == 7'b1110011);
   e.op1_sel   = e.is_branch || is_jal || (opc == 7'b0010111);   // PC base
   e.op2_sel   = !((opc == 7'b0110011) || e.is_system);
   e.reg_wb_en = !(e.is_store || e.is_branch || e.is_system);
   e.wb_sel    = e.is_load ? rv_decode_pkg::WB_MEM :
                 (e.is_jump ? rv_decode_pkg::WB_PC4 : rv_decode_pkg::WB_ALU);
   e.ex_op     = is_alu ? rv_decode_pkg::EX_FUNCT :
                 (e.is_branch ? rv_decode_pkg::EX_BRANCH : rv_decode_pkg::EX_ADD);
   if (e.is_load) begin
      case (ins[14:12])
         3'd0:    e.mem_op = rv_decode_pkg::MEM_LB;
         3'd1:    e.mem_op = rv_decode_pkg::MEM_LH;
         3'd2:    e.mem_op = rv_decode_pkg::MEM_LW;
         3'd4:    e.mem_op = rv_decode_pkg::MEM_LBU;
         3'd5:    e.mem_op = rv_decode_pkg::MEM_LHU;
         default: e.mem_op = rv_decode_pkg::MEM_NONE;
      endcase
   end else if (e.is_store) begin
      case (ins[14:12])
         3'd0:    e.mem_op = rv_decode_pkg::MEM_SB;
         3'd1:    e.mem_op = rv_decode_pkg::MEM_SH;
         3'd2:    e.mem_op = rv_decode_pkg::MEM_SW;
         default: e.mem_op = rv_decode_pkg::MEM_NONE;
      endcase
   end
   return e;
endfunction

`endif

/* bench/id_stage_tb.sv */
`timescale 1ns/100ps
`include "rv_decode_cfg.svh"

module id_stage_tb;

   localparam int NUM_CYCLES   = 2000;
   localparam int MID_RESET_AT = 1200;   // Start of the mid-run reset

   logic                  clk_i;
   logic                  rst_n_i;
   logic [31:2]           instr_i;
   logic [`RV_PC_W-1:0]   pc_i;
   logic                  busywait_i;
   logic                  flush_i;
   rv_decode_pkg::rf_wr_t wr_i;
   logic                  stall_o;
   rv_decode_pkg::id_ex_t id_ex_o;

   integer                seed;
   int                    errors;
   int                    checks;
   int                    stalls;
   logic                  stall_seen;
   logic                  flush_seen;
   rv_decode_pkg::id_ex_t exp_q;          // Expected ID/EX register
   logic [6:0]            legal_ops [10];

   `include "id_stage_model.svh"

   instruction_decode_stage dut_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .instr_i    (instr_i),
      .pc_i       (pc_i),
      .busywait_i (busywait_i),
      .flush_i    (flush_i),
      .wr_i       (wr_i),
      .stall_o    (stall_o),
      .id_ex_o    (id_ex_o)
   );

   always #5 clk_i = ~clk_i;

   task automatic check_value(input string what, input logic [255:0] got,
                              input logic [255:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // Mostly x0..x7 so hazards and bypass hits come often
   function automatic logic [4:0] random_reg();
      logic [31:0] r;
      r = $random(seed);
      return (r[31:30] == 2'b00) ? r[4:0] : {2'b00, r[2:0]};
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus at the rising edge, checks at the falling edge
   ////////////////////////////////////////////////////////////

   task automatic drive_inputs(input int cyc);
      logic [31:0]           ins;
      logic [31:0]           r;
      rv_decode_pkg::rf_wr_t w;
      rst_n_i <= !((cyc < 3) || ((cyc >= MID_RESET_AT) && (cyc < MID_RESET_AT + 3)));
      if (!stall_seen) begin   // Fetch holds while stalled
         ins        = $random(seed);
         r          = $random(seed);
         ins[6:0]   = legal_ops[r % 10];
         ins[11:7]  = random_reg();
         ins[19:15] = random_reg();
         ins[24:20] = random_reg();
         instr_i    <= ins[31:2];
         r          = $random(seed);
         pc_i       <= flush_seen ? r[29:0] : pc_i + 30'd1;   // Redirect after flush
      end
      r          = $random(seed);
      busywait_i <= (r % 100) < 10;
      r          = $random(seed);
      flush_i    <= (r % 100) < 5;
      r          = $random(seed);
      w.en       = r[0];
      w.addr     = random_reg();
      w.data     = $random(seed);
      wr_i       <= w;
   endtask

   task automatic check_cycle();
      rv_decode_pkg::id_ex_t nxt;
      logic                  exp_stall;
      if (!rst_n_i) begin
         clear_shadow();
         exp_q = '0;
      end
      exp_stall = expected_stall(exp_q, {instr_i, 2'b11});
      check_value("stall_o", stall_o, exp_stall);
      check_value("id_ex_o.rs1_val", id_ex_o.rs1_val, exp_q.rs1_val);
      check_value("id_ex_o.rs2_val", id_ex_o.rs2_val, exp_q.rs2_val);
      check_value("id_ex_o", id_ex_o, exp_q);
      stalls     += exp_stall;
      stall_seen = stall_o;
      flush_seen = flush_i;
      // Next edge, same priority as the pipeline register
      if (!rst_n_i || flush_i)
         nxt = '0;
      else if (busywait_i)
         nxt = exp_q;
      else if (exp_stall)
         nxt = '0;
      else
         nxt = expected_decode({instr_i, 2'b11}, pc_i, wr_i);
      if (rst_n_i && wr_i.en && (wr_i.addr != 5'd0))
         shadow_rf[wr_i.addr] = wr_i.data;
      exp_q = nxt;
   endtask

   initial begin
      seed       = 32'h6ae0a03f;
      legal_ops  = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1100111, 7'b1101111,
                     7'b0010011, 7'b0110011, 7'b0110111, 7'b0010111, 7'b1110011};
      clk_i      = 1'b0;
      rst_n_i    = 1'b0;
      instr_i    = '0;
      pc_i       = '0;
      busywait_i = 1'b0;
      flush_i    = 1'b0;
      wr_i       = '0;
      errors     = 0;
      checks     = 0;
      stalls     = 0;
      stall_seen = 1'b0;
      flush_seen = 1'b0;
      exp_q      = '0;
      clear_shadow();
      for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
         @(posedge clk_i);
         drive_inputs(cyc);
         @(negedge clk_i);
         check_cycle();
      end
      $display("Cycles %0d, stalls %0d, checks %0d, errors %0d",
               NUM_CYCLES, stalls, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // 1.5 times the run length at 10 ns per cycle
   initial begin
      #(NUM_CYCLES * 15);
      $display("Watchdog expired at %0t before the test sequence finished", $time);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

/* source/instruction_decode_stage.sv */
`timescale 1ns/100ps
`include "rv_decode_cfg.svh"

module instruction_decode_stage (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [`RV_XLEN-1:2]     instr_i,     // Bits 1:0 are 11
   input  logic [`RV_PC_W-1:0]     pc_i,
   input  logic                    busywait_i,
   input  logic                    flush_i,
   input  rv_decode_pkg::rf_wr_t   wr_i,
   output logic                    stall_o,
   output rv_decode_pkg::id_ex_t   id_ex_o
);

   ////////////////////////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////////////////////////

   logic [6:0]              opcode;
   logic [`RV_RADDR_W-1:0]  rd;
   logic [`RV_RADDR_W-1:0]  rs1;
   logic [`RV_RADDR_W-1:0]  rs2;
   logic [2:0]              funct3;
   logic [6:0]              funct7;

   assign opcode = {instr_i[6:2], 2'b11};
   assign rd     = instr_i[11:7];
   assign funct3 = instr_i[14:12];
   assign rs1    = instr_i[19:15];
   assign rs2    = instr_i[24:20];
   assign funct7 = instr_i[31:25];

   rv_decode_pkg::ctrl_t   ctrl;
   logic [`RV_XLEN-1:0]    imm;
   logic [`RV_XLEN-1:0]    rs1_val;
   logic [`RV_XLEN-1:0]    rs2_val;
   rv_decode_pkg::id_ex_t  id_ex_d;
   rv_decode_pkg::id_ex_t  id_ex_q;

   main_decoder u_main_decoder (
      .opcode_i (opcode),
      .funct3_i (funct3),
      .ctrl_o   (ctrl)
   );

   imm_gen u_imm_gen (
      .instr_i  (instr_i[31:7]),
      .fmt_i    (ctrl.imm_fmt),
      .imm_o    (imm)
   );

   // Written from write-back, read here
   regfile u_regfile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_i       (wr_i),
      .rs1_i      (rs1),
      .rs2_i      (rs2),
      .rs1_data_o (rs1_val),
      .rs2_data_o (rs2_val)
   );

   ////////////////////////////////////////////////////////////
   // Load-use hazard
   ////////////////////////////////////////////////////////////

   // Load in EX whose rd feeds this instruction, field match for any opcode
   assign stall_o = id_ex_q.is_load && (id_ex_q.rd != '0) &&
                    ((id_ex_q.rd == rs1) || (id_ex_q.rd == rs2));

   ////////////////////////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////////////////////////

   always_comb begin
      id_ex_d           = '0;
      id_ex_d.pc        = pc_i;
      id_ex_d.rs1_val   = rs1_val;
      id_ex_d.rs2_val   = rs2_val;
      id_ex_d.imm       = imm;
      id_ex_d.op1_sel   = ctrl.op1_sel;
      id_ex_d.op2_sel   = ctrl.op2_sel;
      id_ex_d.mem_op    = ctrl.mem_op;
      id_ex_d.wb_sel    = ctrl.wb_sel;
      id_ex_d.reg_wb_en = ctrl.reg_wb_en;
      id_ex_d.rd        = rd;
      id_ex_d.rs1       = rs1;
      id_ex_d.rs2       = rs2;
      id_ex_d.funct3    = funct3;
      id_ex_d.funct7    = funct7;
      id_ex_d.ex_op     = ctrl.ex_op;
      id_ex_d.is_load   = ctrl.is_load;
      id_ex_d.is_store  = ctrl.is_store;
      id_ex_d.is_branch = ctrl.is_branch;
      id_ex_d.is_jump   = ctrl.is_jump;
      id_ex_d.is_system = ctrl.is_system;
   end

   // Priority is flush, then busywait hold, then stall bubble
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         id_ex_q <= '0;
      end else if (flush_i) begin
         id_ex_q <= '0;
      end else if (!busywait_i) begin
         id_ex_q <= stall_o ? '0 : id_ex_d;   // Bubble keeps EX idle
      end
   end

   assign id_ex_o = id_ex_q;

   // A stall can only come from a load sitting in EX
   stall_needs_load_a : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) stall_o |-> id_ex_o.is_load
   ) else $error("id stage: stall without a load in EX");

   flush_kills_wb_a : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) flush_i |=> !id_ex_o.reg_wb_en
   ) else $error("id stage: write-back enabled after flush");

endmodule

/* source/regfile.sv */
`timescale 1ns/100ps
`include "rv_decode_cfg.svh"

module regfile (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  rv_decode_pkg::rf_wr_t     wr_i,
   input  logic [`RV_RADDR_W-1:0]    rs1_i,
   input  logic [`RV_RADDR_W-1:0]    rs2_i,
   output logic [`RV_XLEN-1:0]       rs1_data_o,
   output logic [`RV_XLEN-1:0]       rs2_data_o
);

   logic [`RV_XLEN-1:0] regs_q [1:`RV_NREGS-1];   // No storage for x0

   // x0 is zero, a same-cycle write wins over the stored word
   function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_RADDR_W-1:0] addr);
      if (addr == '0)
         return '0;
      if (wr_i.en && (wr_i.addr == addr))
         return wr_i.data;
      return regs_q[addr];
   endfunction

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < `RV_NREGS; i++)
            regs_q[i] <= '0;
      end else if (wr_i.en && (wr_i.addr != '0)) begin
         regs_q[wr_i.addr] <= wr_i.data;
      end
   end

   always_comb begin
      rs1_data_o = read_port(rs1_i);
      rs2_data_o = read_port(rs2_i);
   end

   x0_reads_zero_a : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
         ((rs1_i == '0) |-> (rs1_data_o == '0)) and ((rs2_i == '0) |-> (rs2_data_o == '0))
   ) else $error("regfile: x0 read returned nonzero");

endmodule

/* source/imm_gen.sv */
`timescale 1ns/100ps
`include "rv_decode_cfg.svh"

module imm_gen (
   input  logic [31:7]               instr_i,
   input  rv_decode_pkg::imm_fmt_e   fmt_i,
   output logic [`RV_XLEN-1:0]       imm_o
);

   logic sign;

   assign sign = instr_i[31];   // Every format takes its sign from bit 31

   ////////////////////////////////////////////////////////////
   // Field assembly per format
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (fmt_i)
         rv_decode_pkg::IMM_I: begin
            imm_o = {{21{sign}}, instr_i[30:20]};
         end
         rv_decode_pkg::IMM_S: begin
            imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
         end
         rv_decode_pkg::IMM_B: begin
            // Halfword offset
            imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
         end
         rv_decode_pkg::IMM_U: begin
            imm_o = {instr_i[31:12], 12'b0};   // Upper 20 bits
         end
         rv_decode_pkg::IMM_J: begin
            imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
         end
         default: imm_o = '0;
      endcase
   end

endmodule

/* source/main_decoder.sv */
`timescale 1ns/100ps

module main_decoder (
   input  logic [6:0]           opcode_i,
   input  logic [2:0]           funct3_i,
   output rv_decode_pkg::ctrl_t ctrl_o
);

   rv_decode_pkg::opcode_e opcode;
   rv_decode_pkg::mem_op_e load_op;
   rv_decode_pkg::mem_op_e store_op;
   logic                   known_op;

   assign opcode = rv_decode_pkg::opcode_e'(opcode_i);

   ////////////////////////////////////////////////////////////
   // Access width from funct3
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (funct3_i)
         3'b000:  load_op = rv_decode_pkg::MEM_LB;
         3'b001:  load_op = rv_decode_pkg::MEM_LH;
         3'b010:  load_op = rv_decode_pkg::MEM_LW;
         3'b100:  load_op = rv_decode_pkg::MEM_LBU;
         3'b101:  load_op = rv_decode_pkg::MEM_LHU;
         default: load_op = rv_decode_pkg::MEM_NONE;
      endcase
      case (funct3_i)
         3'b000:  store_op = rv_decode_pkg::MEM_SB;
         3'b001:  store_op = rv_decode_pkg::MEM_SH;
         3'b010:  store_op = rv_decode_pkg::MEM_SW;
         default: store_op = rv_decode_pkg::MEM_NONE;   // Reserved widths
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Opcode decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      ctrl_o   = '0;   // Zero is a bubble
      known_op = 1'b1;
      case (opcode)
         rv_decode_pkg::LOAD: begin
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.mem_op    = load_op;
            ctrl_o.wb_sel    = rv_decode_pkg::WB_MEM;
            ctrl_o.reg_wb_en = 1'b1;
            ctrl_o.is_load   = 1'b1;
         end
         rv_decode_pkg::STORE: begin
            ctrl_o.op2_sel  = 1'b1;
            ctrl_o.mem_op   = store_op;
            ctrl_o.imm_fmt  = rv_decode_pkg::IMM_S;
            ctrl_o.is_store = 1'b1;
         end
         rv_decode_pkg::BRANCH: begin
            // Adder forms PC + imm while the comparator sees rs1 and rs2
            ctrl_o.op1_sel   = 1'b1;
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.imm_fmt   = rv_decode_pkg::IMM_B;
            ctrl_o.ex_op     = rv_decode_pkg::EX_BRANCH;
            ctrl_o.is_branch = 1'b1;
         end
         rv_decode_pkg::JALR, rv_decode_pkg::JAL: begin
            ctrl_o.op1_sel   = (opcode == rv_decode_pkg::JAL);
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.wb_sel    = rv_decode_pkg::WB_PC4;
            ctrl_o.reg_wb_en = 1'b1;
            ctrl_o.imm_fmt   = (opcode == rv_decode_pkg::JAL) ? rv_decode_pkg::IMM_J
                                                               : rv_decode_pkg::IMM_I;
            ctrl_o.is_jump   = 1'b1;
         end
         rv_decode_pkg::OP_IMM, rv_decode_pkg::OP: begin
            ctrl_o.op2_sel   = (opcode == rv_decode_pkg::OP_IMM);
            ctrl_o.reg_wb_en = 1'b1;
            ctrl_o.ex_op     = rv_decode_pkg::EX_FUNCT;
         end
         rv_decode_pkg::LUI, rv_decode_pkg::AUIPC: begin
            ctrl_o.op1_sel   = (opcode == rv_decode_pkg::AUIPC);   // LUI passes imm
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.reg_wb_en = 1'b1;
            ctrl_o.imm_fmt   = rv_decode_pkg::IMM_U;
         end
         rv_decode_pkg::SYSTEM: ctrl_o.is_system = 1'b1;
         default:               known_op         = 1'b0;
      endcase
   end

   // Fetch must only hand over legal major opcodes
   always_comb begin
      if (!$isunknown(opcode_i)) begin
         unknown_opcode_a : assert final (known_op)
            else $error("main_decoder: unknown opcode %b", opcode_i);
      end
   end

endmodule

/* source/rv_decode_pkg.sv */
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////

   // Major opcodes, low two bits always 11
   typedef enum logic [6:0] {
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JALR   = 7'b1100111,
      JAL    = 7'b1101111,
      OP_IMM = 7'b0010011,
      OP     = 7'b0110011,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      SYSTEM = 7'b1110011
   } opcode_e;

   typedef enum logic [2:0] {
      IMM_I = 3'd0,
      IMM_S = 3'd1,
      IMM_B = 3'd2,
      IMM_U = 3'd3,
      IMM_J = 3'd4
   } imm_fmt_e;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2   // Link address for JAL and JALR
   } wb_sel_e;

   typedef enum logic [1:0] {
      EX_ADD    = 2'd0,   // Address calc or pass
      EX_FUNCT  = 2'd1,   // ALU op from funct3 and funct7
      EX_BRANCH = 2'd2    // Compare rs1 against rs2
   } ex_op_e;

   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,
      MEM_LB   = 4'd1,
      MEM_LH   = 4'd2,
      MEM_LW   = 4'd3,
      MEM_LBU  = 4'd4,
      MEM_LHU  = 4'd5,
      MEM_SB   = 4'd6,
      MEM_SH   = 4'd7,
      MEM_SW   = 4'd8
   } mem_op_e;

   ////////////////////////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////////////////////////

   // ID/EX pipeline payload
   typedef struct packed {
      logic [`RV_PC_W-1:0]    pc;
      logic [`RV_XLEN-1:0]    rs1_val;
      logic [`RV_XLEN-1:0]    rs2_val;
      logic [`RV_XLEN-1:0]    imm;
      logic                   op1_sel;   // 1 selects PC
      logic                   op2_sel;   // 1 selects imm
      mem_op_e                mem_op;
      wb_sel_e                wb_sel;
      logic                   reg_wb_en;
      logic [`RV_RADDR_W-1:0] rd;
      logic [`RV_RADDR_W-1:0] rs1;
      logic [`RV_RADDR_W-1:0] rs2;
      logic [2:0]             funct3;
      logic [6:0]             funct7;
      ex_op_e                 ex_op;
      logic                   is_load;
      logic                   is_store;
      logic                   is_branch;
      logic                   is_jump;
      logic                   is_system;
   } id_ex_t;

   // Write port from write-back
   typedef struct packed {
      logic                   en;
      logic [`RV_RADDR_W-1:0] addr;
      logic [`RV_XLEN-1:0]    data;
   } rf_wr_t;

   typedef struct packed {
      logic     op1_sel;
      logic     op2_sel;
      mem_op_e  mem_op;
      wb_sel_e  wb_sel;
      logic     reg_wb_en;
      imm_fmt_e imm_fmt;
      ex_op_e   ex_op;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      logic     is_jump;
      logic     is_system;
   } ctrl_t;

endpackage

/* source/rv_decode_cfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

////////////////////////////////////////////////////////////
// RV32I widths, fixed by the ISA
////////////////////////////////////////////////////////////

// Data path and register width
`define RV_XLEN 32

// Stored PC bits 31:2, word aligned
`define RV_PC_W 30

// Architectural registers, x0 included
`define RV_NREGS 32

`define RV_RADDR_W 5   // log2 of RV_NREGS

`endif
